/* verification/wisc_proc_golden.txt */
// Columns: tag(1 hex) reg(1 hex) value(4 hex); tag 1 = program word in load order,
// tag 2 = expected write-back of value to reg, tag 3 = final err flag in bit 0
10C105 // 0  LBI r1, 5
10C2FD // 1  LBI r2, -3
10D94C // 2  ADD r3, r1, r2
10D951 // 3  SUB r4, r1, r2
10D956 // 4  XOR r5, r1, r2
10D95B // 5  AND r6, r1, r2
1043E7 // 6  ADDI r7, r3, 7
1047FE // 7  ADDI r7, r7, -2
108182 // 8  ST r4, r1, 2
108942 // 9  LD r2, r1, 2
10DA4C // 10 ADD r3, r2, r2
10F800 // 11 unknown opcode
104121 // 12 ADDI r1, r1, 1
10C000 // 13 LBI r0, 0
106004 // 14 BEQZ r0, +4 taken
10C511 // 15 skipped
10C622 // 16 skipped
106804 // 17 BNEZ r0, +4 not taken
10C433 // 18 LBI r4, 0x33
102004 // 19 J +4
10C544 // 20 skipped
10C655 // 21 skipped
1044C1 // 22 ADDI r6, r4, 1
100000 // 23 HALT
10C766 // 24 never written back
100800 // 25 NOP
100800 // 26 NOP
100800 // 27 NOP
210005
22FFFD
230002
240008
25FFF8
260005
270009
270007
220008 // Load of the stored value
230010
210006 // After the unknown opcode
200000
240033
260034
300001

/* wisc_proc.f */
+incdir+logic
logic/wisc_pkg.sv
logic/fetch.sv
logic/decode.sv
logic/execute.sv
logic/memory.sv
logic/wisc_proc.sv
verification/tb_clock.sv
verification/wisc_proc_tb.sv

/* Bender.yml */
package:
  name: wisc_proc

export_include_dirs:
  - logic

sources:
  - include_dirs:
      - logic
    files:
      - logic/wisc_pkg.sv
      - logic/fetch.sv
      - logic/decode.sv
      - logic/execute.sv
      - logic/memory.sv
      - logic/wisc_proc.sv
  - target: test
    include_dirs:
      - logic
    files:
      - verification/tb_clock.sv
      - verification/wisc_proc_tb.sv

/* verification/wisc_proc_tb.sv */
// ====================================================================
// WISC processor testbench
// Loads the program from the golden file during reset, checks every
// write-back in order, then checks halt, fetch freeze and the err flag
// ====================================================================
`timescale 1ns/1ps
`include "wisc_config.svh"

module wisc_proc_tb;

   localparam int GOLDEN_LEN = 64;
   localparam int RUN_LIMIT  = 500;  // Cycles allowed until halt
   localparam int FREEZE_CYC = 10;
   localparam logic [15:0] NOP_WORD = 16'h0800;  // Opcode 00001, all other fields zero

   logic                     clk, rst, imem_we;
   logic [`WISC_IMEM_AW-1:0] imem_addr;
   logic [`WISC_DATA_W-1:0]  imem_wdata;
   logic [`WISC_DATA_W-1:0]  pc, instruction_f, wb_data;
   logic                     err, halt, wb_en;
   logic [2:0]               wb_reg;

   // Golden entry with tag in 23..20, register in 18..16 and value in 15..0
   logic [23:0] golden [GOLDEN_LEN];
   logic [15:0] prog_words [$];
   logic [18:0] wb_expected [$];
   logic        expected_err;
   logic        halt_seen;
   int          errors;
   int          wb_checked;

   tb_clock clock0 (.clk(clk));

   wisc_proc dut0 (
      .clk           (clk),
      .rst           (rst),
      .imem_we       (imem_we),
      .imem_addr     (imem_addr),
      .imem_wdata    (imem_wdata),
      .pc            (pc),
      .instruction_f (instruction_f),
      .err           (err),
      .halt          (halt),
      .wb_en         (wb_en),
      .wb_reg        (wb_reg),
      .wb_data       (wb_data)
   );

   task automatic check_value(input string name, input logic [31:0] actual,
                              input logic [31:0] expected);
      if (actual !== expected) begin
         errors++;
         $display("ERROR %s: got 0x%0h, expected 0x%0h at %0t ns", name, actual, expected,
                  $time);
      end
   endtask

   task automatic read_golden();
      logic [23:0] entry;
      for (int i = 0; i < GOLDEN_LEN; i++) begin
         golden[i] = '0;  // Tag 0 marks an unused slot
      end
      $readmemh("verification/wisc_proc_golden.txt", golden);
      expected_err = 1'b0;
      for (int i = 0; i < GOLDEN_LEN; i++) begin
         entry = golden[i];
         case (entry[23:20])
            4'h1:    prog_words.push_back(entry[15:0]);
            4'h2:    wb_expected.push_back(entry[18:0]);
            4'h3:    expected_err = entry[0];
            default: ;
         endcase
      end
      if (prog_words.size() == 0) begin
         errors++;
         $display("The golden file holds no program words");
      end
   endtask

   // Pipeline state while reset is still held
   task automatic verify_reset_state();
      check_value("pc", pc, 0);
      check_value("instruction_f", instruction_f, NOP_WORD);
      check_value("halt", halt, 1'b0);
      check_value("err", err, 1'b0);
      check_value("wb_en", wb_en, 1'b0);
   endtask

   // Next expected write-back in program order
   task automatic compare_writeback();
      logic [18:0] exp_wb;
      if (wb_expected.size() == 0) begin
         errors++;
         $display("Unexpected write-back of 0x%0h to r%0d after the expected sequence ended",
                  wb_data, wb_reg);
      end else begin
         exp_wb = wb_expected.pop_front();
         check_value("wb_reg", wb_reg, exp_wb[18:16]);
         check_value("wb_data", wb_data, exp_wb[15:0]);
         wb_checked++;
      end
   endtask

   task automatic wait_for_halt(output logic seen);
      int cycles;
      cycles = 0;
      while (halt !== 1'b1 && cycles < RUN_LIMIT) begin
         @(negedge clk);
         cycles++;
      end
      seen = (halt === 1'b1);
      if (!seen) begin
         errors++;
         $display("Timeout: halt did not rise within %0d cycles", RUN_LIMIT);
      end
   endtask

   task automatic check_fetch_frozen();
      logic [`WISC_DATA_W-1:0] pc_at_halt;
      logic [`WISC_DATA_W-1:0] instr_at_halt;
      pc_at_halt    = pc;
      instr_at_halt = instruction_f;
      repeat (FREEZE_CYC) begin
         @(negedge clk);
         check_value("pc", pc, pc_at_halt);
         check_value("instruction_f", instruction_f, instr_at_halt);
         check_value("halt", halt, 1'b1);
      end
   endtask

   // Each write-back is checked on the falling edge
   always @(negedge clk) begin
      if (!rst && wb_en === 1'b1) begin
         compare_writeback();
      end
   end

   initial begin
      rst        = 1'b1;
      imem_we    = 1'b0;
      imem_addr  = '0;
      imem_wdata = '0;
      errors     = 0;
      wb_checked = 0;
      read_golden();

      // One program word per cycle while reset is held
      foreach (prog_words[i]) begin
         @(posedge clk);
         #1;
         imem_we    = 1'b1;
         imem_addr  = i;
         imem_wdata = prog_words[i];
      end
      @(posedge clk);
      #1;
      imem_we = 1'b0;
      repeat (8) @(posedge clk);
      #1;
      verify_reset_state();
      rst = 1'b0;

      wait_for_halt(halt_seen);
      if (halt_seen) begin
         check_fetch_frozen();
         check_value("pending write-backs", wb_expected.size(), 0);
         check_value("err", err, expected_err);
      end

      $display("Summary: %0d errors, %0d write-backs checked", errors, wb_checked);
      if (errors == 0) begin
         $display(">>> PASS");
      end else begin
         $display(">>> FAIL");
      end
      $finish;
   end

endmodule

/* verification/tb_clock.sv */
// ====================================================================
// Testbench clock generator
// Free-running 10 ns clock for the WISC processor testbench
// ====================================================================
`timescale 1ns/1ps

module tb_clock #(
   parameter real HALF_NS = 5.0  // Half of the 10 ns period
) (
   output logic clk
);

   initial begin
      clk = 1'b0;
      forever #(HALF_NS) clk = ~clk;
   end

endmodule

/* logic/wisc_proc.sv */
// ====================================================================
// WISC five-stage pipelined processor
// Fetch, decode, execute and memory stages; write-back is driven from
// the memory stage register straight into the register file
// ====================================================================
`timescale 1ns/1ps
`include "wisc_config.svh"

module wisc_proc (
   input  logic                     clk,
   input  logic                     rst,
   input  logic                     imem_we,
   input  logic [`WISC_IMEM_AW-1:0] imem_addr,
   input  logic [`WISC_DATA_W-1:0]  imem_wdata,
   output logic [`WISC_DATA_W-1:0]  pc,
   output logic [`WISC_DATA_W-1:0]  instruction_f,
   output logic                     err,
   output logic                     halt,
   output logic                     wb_en,
   output logic [2:0]               wb_reg,
   output logic [`WISC_DATA_W-1:0]  wb_data
);

   // Hazard and redirect paths
   logic                    stall, redirect, ex_writes, mem_writes;
   logic [`WISC_DATA_W-1:0] redirect_pc;
   logic [2:0]              ex_dest, mem_dest;

   logic [`WISC_DATA_W-1:0] pc_next_d, pc_next_e;
   logic [`WISC_DATA_W-1:0] op_a, op_b, imm;
   wisc_pkg::alu_op_e       alu_op;
   logic [1:0]              br_kind;
   logic [2:0]              dest_reg, dest_m;
   logic                    alu_src, mem_read, mem_write, reg_write, halt_e;
   logic [`WISC_DATA_W-1:0] alu_m, store_m;
   logic                    reg_write_m, mem_read_m, mem_write_m, halt_m;

   fetch fetch0 (
      .clk         (clk),
      .rst         (rst),
      .stall       (stall),
      .redirect    (redirect),
      .redirect_pc (redirect_pc),
      .halted      (halt),
      .imem_we     (imem_we),
      .imem_addr   (imem_addr),
      .imem_wdata  (imem_wdata),
      .pc          (pc),
      .instr_d     (instruction_f),  // Word leaving fetch
      .pc_next_d   (pc_next_d)
   );

   decode decode0 (
      .clk        (clk),
      .rst        (rst),
      .instr_d    (instruction_f),
      .pc_next_d  (pc_next_d),
      .redirect   (redirect),
      .ex_dest    (ex_dest),
      .ex_writes  (ex_writes),
      .mem_dest   (mem_dest),
      .mem_writes (mem_writes),
      .wb_en      (wb_en),
      .wb_reg     (wb_reg),
      .wb_data    (wb_data),
      .stall      (stall),
      .err        (err),
      .op_a       (op_a),
      .op_b       (op_b),
      .imm        (imm),
      .alu_op     (alu_op),
      .alu_src    (alu_src),
      .br_kind    (br_kind),
      .mem_read   (mem_read),
      .mem_write  (mem_write),
      .reg_write  (reg_write),
      .dest_reg   (dest_reg),
      .halt_e     (halt_e),
      .pc_next_e  (pc_next_e)
   );

   execute execute0 (
      .clk         (clk),
      .rst         (rst),
      .op_a        (op_a),
      .op_b        (op_b),
      .imm         (imm),
      .alu_op      (alu_op),
      .alu_src     (alu_src),
      .br_kind     (br_kind),
      .mem_read    (mem_read),
      .mem_write   (mem_write),
      .reg_write   (reg_write),
      .dest_reg    (dest_reg),
      .halt_e      (halt_e),
      .pc_next_e   (pc_next_e),
      .redirect    (redirect),
      .redirect_pc (redirect_pc),
      .ex_dest     (ex_dest),
      .ex_writes   (ex_writes),
      .alu_m       (alu_m),
      .store_m     (store_m),
      .dest_m      (dest_m),
      .reg_write_m (reg_write_m),
      .mem_read_m  (mem_read_m),
      .mem_write_m (mem_write_m),
      .halt_m      (halt_m)
   );

   memory memory0 (
      .clk         (clk),
      .rst         (rst),
      .alu_m       (alu_m),
      .store_m     (store_m),
      .dest_m      (dest_m),
      .reg_write_m (reg_write_m),
      .mem_read_m  (mem_read_m),
      .mem_write_m (mem_write_m),
      .halt_m      (halt_m),
      .mem_dest    (mem_dest),
      .mem_writes  (mem_writes),
      .wb_en       (wb_en),
      .wb_reg      (wb_reg),
      .wb_data     (wb_data),
      .halt        (halt)
   );

endmodule

/* logic/memory.sv */
// ====================================================================
// Memory stage
// Data memory, write-back value selection, the memory/write-back
// register and the halt flag
// ====================================================================
`timescale 1ns/1ps
`include "wisc_config.svh"

module memory (
   input  logic                    clk,
   input  logic                    rst,
   input  logic [`WISC_DATA_W-1:0] alu_m,
   input  logic [`WISC_DATA_W-1:0] store_m,
   input  logic [2:0]              dest_m,
   input  logic                    reg_write_m,
   input  logic                    mem_read_m,
   input  logic                    mem_write_m,
   input  logic                    halt_m,
   output logic [2:0]              mem_dest,
   output logic                    mem_writes,
   output logic                    wb_en,
   output logic [2:0]              wb_reg,
   output logic [`WISC_DATA_W-1:0] wb_data,
   output logic                    halt
);

   logic [`WISC_DATA_W-1:0]            dmem [`WISC_DMEM_DEPTH];
   logic [$clog2(`WISC_DMEM_DEPTH)-1:0] daddr;

   assign daddr      = alu_m[$clog2(`WISC_DMEM_DEPTH)-1:0]; // Word address
   assign mem_dest   = dest_m;
   assign mem_writes = reg_write_m;

   always_ff @(posedge clk) begin
      if (mem_write_m) begin
         dmem[daddr] <= store_m;
      end
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         wb_en <= 1'b0;
         halt  <= 1'b0;
      end else begin
         wb_en <= reg_write_m;
         if (halt_m) begin
            halt <= 1'b1;
         end
      end
   end

   always_ff @(posedge clk) begin
      wb_reg  <= dest_m;
      wb_data <= mem_read_m ? dmem[daddr] : alu_m;  // Load data or ALU result
   end

endmodule

/* logic/execute.sv */
// ====================================================================
// Execute stage
// ALU, branch and jump resolution, and the execute/memory register
// ====================================================================
`timescale 1ns/1ps
`include "wisc_config.svh"

module execute (
   input  logic                    clk,
   input  logic                    rst,
   input  logic [`WISC_DATA_W-1:0] op_a,
   input  logic [`WISC_DATA_W-1:0] op_b,
   input  logic [`WISC_DATA_W-1:0] imm,
   input  wisc_pkg::alu_op_e       alu_op,
   input  logic                    alu_src,
   input  logic [1:0]              br_kind,
   input  logic                    mem_read,
   input  logic                    mem_write,
   input  logic                    reg_write,
   input  logic [2:0]              dest_reg,
   input  logic                    halt_e,
   input  logic [`WISC_DATA_W-1:0] pc_next_e,
   output logic                    redirect,
   output logic [`WISC_DATA_W-1:0] redirect_pc,
   output logic [2:0]              ex_dest,
   output logic                    ex_writes,
   output logic [`WISC_DATA_W-1:0] alu_m,
   output logic [`WISC_DATA_W-1:0] store_m,
   output logic [2:0]              dest_m,
   output logic                    reg_write_m,
   output logic                    mem_read_m,
   output logic                    mem_write_m,
   output logic                    halt_m
);

   logic [`WISC_DATA_W-1:0] alu_b, alu_y;
   logic                    a_zero, taken;

   assign alu_b = alu_src ? imm : op_b;

   always_comb begin
      case (alu_op)
         wisc_pkg::ALU_ADD:   alu_y = op_a + alu_b;
         wisc_pkg::ALU_SUB:   alu_y = op_a - alu_b;
         wisc_pkg::ALU_AND:   alu_y = op_a & alu_b;
         wisc_pkg::ALU_XOR:   alu_y = op_a ^ alu_b;
         wisc_pkg::ALU_PASSB: alu_y = alu_b;
         default:             alu_y = '0;
      endcase
   end

   // Predicted not taken, so any taken transfer redirects
   assign a_zero = (op_a == '0);
   assign taken  = (br_kind == 2'd3) ||
                   (br_kind == 2'd1 && a_zero) ||
                   (br_kind == 2'd2 && !a_zero);
   assign redirect    = taken && !halt_m;  // Nothing moves behind a HALT
   assign redirect_pc = pc_next_e + imm;

   // Seen by decode for stall detection
   assign ex_dest   = dest_reg;
   assign ex_writes = reg_write;

   always_ff @(posedge clk) begin
      if (rst) begin
         reg_write_m <= 1'b0;
         mem_read_m  <= 1'b0;
         mem_write_m <= 1'b0;
         halt_m      <= 1'b0;
      end else if (!halt_m) begin  // Frozen once HALT reaches memory
         reg_write_m <= reg_write;
         mem_read_m  <= mem_read;
         mem_write_m <= mem_write;
         halt_m      <= halt_e;
      end
   end

   always_ff @(posedge clk) begin
      if (!halt_m) begin
         alu_m   <= alu_y;
         store_m <= op_b;
         dest_m  <= dest_reg;
      end
   end

endmodule

/* logic/decode.sv */
// ====================================================================
// Decode stage
// Control decode, register file, immediate extension, hazard stall
// and the decode/execute pipeline register
// ====================================================================
`timescale 1ns/1ps
`include "wisc_config.svh"

module decode (
   input  logic                    clk,
   input  logic                    rst,
   input  logic [`WISC_DATA_W-1:0] instr_d,
   input  logic [`WISC_DATA_W-1:0] pc_next_d,
   input  logic                    redirect,
   input  logic [2:0]              ex_dest,
   input  logic                    ex_writes,
   input  logic [2:0]              mem_dest,
   input  logic                    mem_writes,
   input  logic                    wb_en,
   input  logic [2:0]              wb_reg,
   input  logic [`WISC_DATA_W-1:0] wb_data,
   output logic                    stall,
   output logic                    err,
   output logic [`WISC_DATA_W-1:0] op_a,
   output logic [`WISC_DATA_W-1:0] op_b,
   output logic [`WISC_DATA_W-1:0] imm,
   output wisc_pkg::alu_op_e       alu_op,
   output logic                    alu_src,
   output logic [1:0]              br_kind,   // 0 none, 1 BEQZ, 2 BNEZ, 3 J
   output logic                    mem_read,
   output logic                    mem_write,
   output logic                    reg_write,
   output logic [2:0]              dest_reg,
   output logic                    halt_e,
   output logic [`WISC_DATA_W-1:0] pc_next_e
);

   logic [`WISC_DATA_W-1:0] regs [`WISC_NUM_REGS];
   wisc_pkg::opcode_e       opcode;
   wisc_pkg::alu_op_e       ctl_alu_op;
   logic [2:0]              rs, rt, rd, ctl_dest;
   logic [1:0]              ctl_br;
   logic                    ctl_alu_src, ctl_mem_rd, ctl_mem_wr, ctl_reg_wr, ctl_halt;
   logic                    use_rs, use_rt, illegal, rs_busy, rt_busy;
   logic [`WISC_DATA_W-1:0] imm5, imm8, imm11, ctl_imm, rd_a, rd_b;

   assign opcode = wisc_pkg::opcode_e'(instr_d[15:11]);
   assign rs     = instr_d[10:8];
   assign rt     = instr_d[7:5];
   assign rd     = instr_d[4:2];
   assign imm5   = {{(`WISC_DATA_W-5){instr_d[4]}}, instr_d[4:0]};
   assign imm8   = {{(`WISC_DATA_W-8){instr_d[7]}}, instr_d[7:0]};
   assign imm11  = {{(`WISC_DATA_W-11){instr_d[10]}}, instr_d[10:0]};

   always_comb begin
      ctl_alu_op  = wisc_pkg::ALU_ADD;
      ctl_alu_src = 1'b0;
      ctl_br      = 2'd0;
      ctl_mem_rd  = 1'b0;
      ctl_mem_wr  = 1'b0;
      ctl_reg_wr  = 1'b0;
      ctl_halt    = 1'b0;
      ctl_dest    = rd;
      ctl_imm     = imm5;
      use_rs      = 1'b0;
      use_rt      = 1'b0;
      illegal     = 1'b0;
      case (opcode)
         wisc_pkg::OP_HALT: ctl_halt = 1'b1;
         wisc_pkg::OP_NOP: ;
         wisc_pkg::OP_ADDI, wisc_pkg::OP_LD: begin
            ctl_alu_src = 1'b1;
            ctl_reg_wr  = 1'b1;
            ctl_mem_rd  = (opcode == wisc_pkg::OP_LD);
            ctl_dest    = rt;
            use_rs      = 1'b1;
         end
         wisc_pkg::OP_ST: begin
            ctl_alu_src = 1'b1;   // Address is rs plus imm5
            ctl_mem_wr  = 1'b1;
            use_rs      = 1'b1;
            use_rt      = 1'b1;   // Store data
         end
         wisc_pkg::OP_LBI: begin
            ctl_alu_op  = wisc_pkg::ALU_PASSB;
            ctl_alu_src = 1'b1;
            ctl_reg_wr  = 1'b1;
            ctl_dest    = rs;
            ctl_imm     = imm8;
         end
         wisc_pkg::OP_RTYPE: begin
            ctl_reg_wr = 1'b1;
            use_rs     = 1'b1;
            use_rt     = 1'b1;
            case (instr_d[1:0])
               2'b00:   ctl_alu_op = wisc_pkg::ALU_ADD;
               2'b01:   ctl_alu_op = wisc_pkg::ALU_SUB;
               2'b10:   ctl_alu_op = wisc_pkg::ALU_XOR;
               default: ctl_alu_op = wisc_pkg::ALU_AND;
            endcase
         end
         wisc_pkg::OP_BEQZ, wisc_pkg::OP_BNEZ: begin
            ctl_br  = (opcode == wisc_pkg::OP_BEQZ) ? 2'd1 : 2'd2;
            ctl_imm = imm8;
            use_rs  = 1'b1;       // Tested against zero
         end
         wisc_pkg::OP_J: begin
            ctl_br  = 2'd3;
            ctl_imm = imm11;
         end
         default: illegal = 1'b1; // Falls through as a NOP
      endcase
   end

   // Register file, write data returned on a same-cycle read
   always_ff @(posedge clk) begin
      if (wb_en) begin
         regs[wb_reg] <= wb_data;
      end
   end

   assign rd_a = (wb_en && wb_reg == rs) ? wb_data : regs[rs];
   assign rd_b = (wb_en && wb_reg == rt) ? wb_data : regs[rt];

   // Wait while a producer sits in execute or memory
   assign rs_busy = (ex_writes && ex_dest == rs) || (mem_writes && mem_dest == rs);
   assign rt_busy = (ex_writes && ex_dest == rt) || (mem_writes && mem_dest == rt);
   assign stall   = (use_rs && rs_busy) || (use_rt && rt_busy);

   always_ff @(posedge clk) begin
      if (rst) begin
         err <= 1'b0;
      end else if (illegal && !redirect) begin
         err <= 1'b1;  // Sticky until reset
      end
   end

   always_ff @(posedge clk) begin
      if (rst || stall || redirect) begin  // Bubble
         br_kind   <= 2'd0;
         mem_read  <= 1'b0;
         mem_write <= 1'b0;
         reg_write <= 1'b0;
         halt_e    <= 1'b0;
      end else begin
         br_kind   <= ctl_br;
         mem_read  <= ctl_mem_rd;
         mem_write <= ctl_mem_wr;
         reg_write <= ctl_reg_wr;
         halt_e    <= ctl_halt;
      end
   end

   always_ff @(posedge clk) begin
      op_a      <= rd_a;
      op_b      <= rd_b;
      imm       <= ctl_imm;
      alu_op    <= ctl_alu_op;
      alu_src   <= ctl_alu_src;
      dest_reg  <= ctl_dest;
      pc_next_e <= pc_next_d;
   end

endmodule

/* logic/fetch.sv */
// ====================================================================
// Fetch stage
// Program counter, instruction memory with its load port, and the
// fetch/decode pipeline register
// ====================================================================
`timescale 1ns/1ps
`include "wisc_config.svh"

module fetch (
   input  logic                     clk,
   input  logic                     rst,
   input  logic                     stall,
   input  logic                     redirect,
   input  logic [`WISC_DATA_W-1:0]  redirect_pc,
   input  logic                     halted,
   input  logic                     imem_we,
   input  logic [`WISC_IMEM_AW-1:0] imem_addr,
   input  logic [`WISC_DATA_W-1:0]  imem_wdata,
   output logic [`WISC_DATA_W-1:0]  pc,
   output logic [`WISC_DATA_W-1:0]  instr_d,
   output logic [`WISC_DATA_W-1:0]  pc_next_d
);

   logic [`WISC_DATA_W-1:0] imem [`WISC_IMEM_DEPTH];
   logic [`WISC_DATA_W-1:0] instr_f;
   logic [`WISC_DATA_W-1:0] pc_inc;

   // Byte address in, word index out
   assign instr_f = imem[pc[`WISC_IMEM_AW:1]];
   assign pc_inc  = pc + (`WISC_DATA_W)'(2);

   // Program load port
   always_ff @(posedge clk) begin
      if (imem_we) begin
         imem[imem_addr] <= imem_wdata;
      end
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         pc        <= '0;
         instr_d   <= {wisc_pkg::OP_NOP, 11'd0};
         pc_next_d <= '0;
      end else if (redirect) begin       // Taken branch wins over a stall
         pc      <= redirect_pc;
         instr_d <= {wisc_pkg::OP_NOP, 11'd0}; // Squash the wrong-path word
      end else if (!stall && !halted) begin
         pc        <= pc_inc;
         instr_d   <= instr_f;
         pc_next_d <= pc_inc;
      end
   end

endmodule

/* logic/wisc_pkg.sv */
// ====================================================================
// WISC processor types
// Instruction opcodes and the ALU operations passed from decode to
// execute
// ====================================================================
package wisc_pkg;

   // Opcode field, instruction bits 15..11
   typedef enum logic [4:0] {
      OP_HALT  = 5'b00000,
      OP_NOP   = 5'b00001,
      OP_J     = 5'b00100,
      OP_ADDI  = 5'b01000,
      OP_BEQZ  = 5'b01100,
      OP_BNEZ  = 5'b01101,
      OP_ST    = 5'b10000,
      OP_LD    = 5'b10001,
      OP_LBI   = 5'b11000,
      OP_RTYPE = 5'b11011  // Operation chosen by bits 1..0
   } opcode_e;

   typedef enum logic [2:0] {
      ALU_ADD,
      ALU_SUB,    // A minus B
      ALU_AND,
      ALU_XOR,
      ALU_PASSB   // Immediate straight through, for LBI
   } alu_op_e;

endpackage

/* logic/wisc_config.svh */
// ====================================================================
// WISC processor configuration
// Data width, register count and memory sizes shared by every stage
// ====================================================================
`ifndef WISC_CONFIG_SVH
`define WISC_CONFIG_SVH

`define WISC_DATA_W      16  // Data and instruction word

`define WISC_NUM_REGS    8   // General purpose registers

// Instruction memory, indexed by the word part of the PC
`define WISC_IMEM_DEPTH  256
`define WISC_IMEM_AW     8

`define WISC_DMEM_DEPTH  256 // Data memory words

`endif
